// ==== verilog/cnn_types_pkg.sv ====
package cnn_types_pkg;

	localparam int WORD_W = 16;
	localparam int ACC_W  = 32;
	localparam int CNT_W  = 8;

	// one 16-bit lane value, operand or result
	typedef logic [WORD_W-1:0] word_t;

	typedef logic signed [ACC_W-1:0] acc_t;	// lane sums and running values

	// K, N, S and the loop indices
	typedef logic [CNT_W-1:0] cnt_t;

	// one beat on the result port
	typedef struct packed {
		word_t word;
		cnt_t  lane;	// 0 for conv
		logic  last;	// final beat of the command
	} out_beat_t;

endpackage

// ==== verilog/cnn_cmd_pkg.sv ====
package cnn_cmd_pkg;

	typedef enum logic [1:0] {
		op_conv    = 2'd0,
		op_maxpool = 2'd1,
		op_avgpool = 2'd2
	} op_t;

	// one engine command, held until the last beat is taken
	typedef struct packed {
		op_t                  op;
		cnn_types_pkg::cnt_t  kernel_size;	// window length K
		cnn_types_pkg::cnt_t  o_side;		// outputs N
		cnn_types_pkg::cnt_t  stride;		// data step between windows
		cnn_types_pkg::word_t bias;			// conv only
	} cmd_t;

	// run covers read issue, drain waits for the last beat
	typedef enum logic [1:0] {
		st_idle  = 2'd0,
		st_run   = 2'd1,
		st_drain = 2'd2
	} ctrl_state_t;

endpackage

// ==== verilog/engine_ctrl.sv ====
`timescale 1ns/1ps

module engine_ctrl #(
	parameter int ADDR_W = 10
) (
	input  logic                 clk,
	input  logic                 rst,
	input  cnn_cmd_pkg::cmd_t    i_cmd,
	input  logic                 i_cmd_valid,
	output logic                 o_cmd_ready,
	input  logic                 i_stage_free,
	input  logic                 i_div_busy,
	input  logic                 i_last_taken,
	output cnn_cmd_pkg::op_t     o_op,
	output logic                 o_rd_en,
	output logic [ADDR_W-1:0]    o_d_addr,
	output logic [ADDR_W-1:0]    o_w_addr,
	output logic                 o_elem_valid,
	output logic                 o_elem_first,
	output logic                 o_elem_last,
	output logic                 o_win_last,
	output cnn_types_pkg::word_t o_bias,
	output cnn_types_pkg::cnt_t  o_kernel
);

	// edges from the last read of a window until its result is seen
	// on i_stage_free (conv) or i_div_busy (avg)
	localparam logic [2:0] SETTLE = 3'd4;

	cnn_cmd_pkg::ctrl_state_t state;
	cnn_cmd_pkg::cmd_t        cmd_q;
	cnn_types_pkg::cnt_t      elem_idx;	// t
	cnn_types_pkg::cnt_t      out_idx;	// j
	logic [ADDR_W-1:0]        win_base;	// j*S
	logic [2:0]               settle_cnt;
	logic                     rd_first;
	logic                     rd_last;
	logic                     rd_win_last;
	logic                     win_start;
	logic                     elem_end;
	logic                     last_win;
	logic                     issue;

	assign win_start = (elem_idx == '0);
	assign elem_end  = (elem_idx == cmd_q.kernel_size - 8'd1);
	assign last_win  = (out_idx == cmd_q.o_side - 8'd1);

	// inside a window reads go back to back, a new window waits for room
	assign issue = (state == cnn_cmd_pkg::st_run) &&
		(!win_start || (settle_cnt == '0 && i_stage_free && !i_div_busy));

	assign o_cmd_ready = (state == cnn_cmd_pkg::st_idle);
	assign o_op        = cmd_q.op;
	assign o_bias      = cmd_q.bias;
	assign o_kernel    = cmd_q.kernel_size;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= cnn_cmd_pkg::st_idle;
			cmd_q    <= '0;
			elem_idx <= '0;
			out_idx  <= '0;
			win_base <= '0;
		end else begin
			case (state)
				cnn_cmd_pkg::st_idle: begin
					if (i_cmd_valid) begin
						cmd_q    <= i_cmd;
						elem_idx <= '0;
						out_idx  <= '0;
						win_base <= '0;
						state    <= cnn_cmd_pkg::st_run;
					end
				end
				cnn_cmd_pkg::st_run: begin
					if (issue && elem_end) begin
						elem_idx <= '0;
						out_idx  <= out_idx + 8'd1;
						win_base <= win_base + ADDR_W'(cmd_q.stride);
						if (last_win) begin
							state <= cnn_cmd_pkg::st_drain;
						end
					end else if (issue) begin
						elem_idx <= elem_idx + 8'd1;
					end
				end
				cnn_cmd_pkg::st_drain: begin
					if (i_last_taken) begin
						state <= cnn_cmd_pkg::st_idle;
					end
				end
				default: state <= cnn_cmd_pkg::st_idle;
			endcase
		end
	end

	// holds off the next window start until the previous result has landed
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			settle_cnt <= '0;
		end else if (issue && elem_end) begin
			settle_cnt <= SETTLE;
		end else if (settle_cnt != '0) begin
			settle_cnt <= settle_cnt - 3'd1;
		end
	end

	// read port and its tags, then tags delayed to meet the data
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_rd_en      <= 1'b0;
			rd_first     <= 1'b0;
			rd_last      <= 1'b0;
			rd_win_last  <= 1'b0;
			o_elem_valid <= 1'b0;
			o_elem_first <= 1'b0;
			o_elem_last  <= 1'b0;
			o_win_last   <= 1'b0;
		end else begin
			o_rd_en      <= issue;
			rd_first     <= issue && win_start;
			rd_last      <= issue && elem_end;
			rd_win_last  <= issue && elem_end && last_win;
			o_elem_valid <= o_rd_en;
			o_elem_first <= rd_first;
			o_elem_last  <= rd_last;
			o_win_last   <= rd_win_last;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			o_d_addr <= win_base + ADDR_W'(elem_idx);	// j*S + t
			o_w_addr <= ADDR_W'(elem_idx);
		end
	end

endmodule

// ==== verilog/mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 i_valid,
	input  logic                 i_first,
	input  logic                 i_last,
	input  cnn_types_pkg::word_t i_data,
	input  cnn_types_pkg::word_t i_weight,
	output cnn_types_pkg::acc_t  o_acc,
	output logic                 o_acc_valid
);

	cnn_types_pkg::acc_t prod;
	cnn_types_pkg::acc_t acc_base;

	assign prod     = $signed(i_data) * $signed(i_weight);	// 16x16 signed into 32
	assign acc_base = i_first ? '0 : o_acc;					// restart per window

	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_acc <= acc_base + prod;
		end
	end

	// sum is complete the cycle after the last element
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_acc_valid <= 1'b0;
		end else begin
			o_acc_valid <= i_valid && i_last;
		end
	end

endmodule

// ==== verilog/pool_lane.sv ====
`timescale 1ns/1ps

module pool_lane (
	input  logic                 clk,
	input  logic                 rst,
	input  cnn_cmd_pkg::op_t     i_op,
	input  logic                 i_valid,
	input  logic                 i_first,
	input  logic                 i_last,
	input  cnn_types_pkg::word_t i_data,
	output cnn_types_pkg::acc_t  o_result,
	output logic                 o_result_valid
);

	cnn_types_pkg::acc_t data_ext;
	cnn_types_pkg::acc_t next_val;

	assign data_ext = cnn_types_pkg::acc_t'($signed(i_data));

	always_comb begin
		if (i_first) begin
			next_val = data_ext;	// first element seeds both max and sum
		end else if (i_op == cnn_cmd_pkg::op_maxpool) begin
			next_val = (data_ext > o_result) ? data_ext : o_result;
		end else begin
			next_val = o_result + data_ext;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_result <= next_val;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= i_valid && i_last;
		end
	end

endmodule

// ==== verilog/lane_reduce.sv ====
`timescale 1ns/1ps

module lane_reduce #(
	parameter int LANES = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_valid,
	input  cnn_types_pkg::acc_t [LANES-1:0] i_accs,
	input  cnn_types_pkg::word_t            i_bias,
	output cnn_types_pkg::word_t            o_word,
	output logic                            o_valid
);

	cnn_types_pkg::acc_t total;

	// bias first, then every lane, wrapping in 32 bits
	always_comb begin
		total = cnn_types_pkg::acc_t'($signed(i_bias));
		for (int i = 0; i < LANES; i++) begin
			total = total + i_accs[i];
		end
	end

	// relu, keep the low word
	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_word <= total[31] ? '0 : total[15:0];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

endmodule

// ==== verilog/avg_divider.sv ====
`timescale 1ns/1ps

module avg_divider #(
	parameter int LANES = 4
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             i_start,
	input  cnn_types_pkg::acc_t  [LANES-1:0] i_sums,
	input  cnn_types_pkg::cnt_t              i_kernel,
	output logic                             o_busy,
	output cnn_types_pkg::word_t [LANES-1:0] o_quot,
	output logic                             o_done
);

	localparam int Q_STEPS = 16;

	logic                running;
	logic [4:0]          step;	// 0..15 quotient bits, 16 applies the sign
	logic                setup;
	cnn_types_pkg::cnt_t divisor;
	logic [31:0]         mag [LANES];
	logic [31:0]         trial [LANES];
	logic [31:0]         rem_q [LANES];
	logic [15:0]         quo_q [LANES];	// dividend bits out, quotient bits in
	logic [LANES-1:0]    neg_q;

	assign setup = i_start && !running;

	// busy also covers the done cycle so no new window starts before the load
	assign o_busy = running | o_done;

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			mag[i]   = i_sums[i][31] ? 32'(-i_sums[i]) : 32'(i_sums[i]);
			trial[i] = {rem_q[i][30:0], quo_q[i][15]};
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			running <= 1'b0;
			step    <= '0;
			o_done  <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (setup) begin
				running <= 1'b1;
				step    <= '0;
			end else if (running && step == 5'(Q_STEPS)) begin
				running <= 1'b0;
				o_done  <= 1'b1;
			end else if (running) begin
				step <= step + 5'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (setup) begin
			divisor <= i_kernel;
			for (int i = 0; i < LANES; i++) begin
				neg_q[i] <= i_sums[i][31];
				rem_q[i] <= mag[i] >> Q_STEPS;	// high part is below K
				quo_q[i] <= mag[i][15:0];
			end
		end else if (running && step < Q_STEPS) begin
			for (int i = 0; i < LANES; i++) begin
				if (trial[i] >= 32'(divisor)) begin
					rem_q[i] <= trial[i] - 32'(divisor);
					quo_q[i] <= {quo_q[i][14:0], 1'b1};
				end else begin
					rem_q[i] <= trial[i];
					quo_q[i] <= {quo_q[i][14:0], 1'b0};
				end
			end
		end else if (running) begin
			for (int i = 0; i < LANES; i++) begin
				o_quot[i] <= neg_q[i] ? -quo_q[i] : quo_q[i];	// truncates toward zero
			end
		end
	end

endmodule

// ==== verilog/result_serializer.sv ====
`timescale 1ns/1ps

module result_serializer #(
	parameter int LANES = 4
) (
	input  logic                             clk,
	input  logic                             rst,
	input  cnn_cmd_pkg::op_t                 i_op,
	input  cnn_types_pkg::word_t             i_conv_word,
	input  logic                             i_conv_valid,
	input  cnn_types_pkg::word_t [LANES-1:0] i_pool_words,
	input  logic                             i_pool_valid,
	input  logic                             i_win_last,
	output logic                             o_stage_free,
	output cnn_types_pkg::out_beat_t         o_out,
	output logic                             o_out_valid,
	input  logic                             i_out_ready,
	output logic                             o_last_taken
);

	cnn_types_pkg::word_t [LANES-1:0] stage_q;
	cnn_types_pkg::cnt_t              stage_cnt;	// words still waiting
	cnn_types_pkg::cnt_t              stage_idx;	// next lane to send
	logic                             stage_last;	// staged window is the final one
	logic                             load_conv;
	logic                             load_pool;
	logic                             out_free;
	logic                             move;

	assign load_conv = i_conv_valid && (i_op == cnn_cmd_pkg::op_conv);
	assign load_pool = i_pool_valid && (i_op != cnn_cmd_pkg::op_conv);

	// output register takes a word when empty or being drained
	assign out_free = !o_out_valid || i_out_ready;
	assign move     = (stage_cnt != '0) && out_free;

	assign o_stage_free = (stage_cnt == '0);
	assign o_last_taken = o_out_valid && i_out_ready && o_out.last;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage_cnt   <= '0;
			stage_idx   <= '0;
			stage_last  <= 1'b0;
			o_out_valid <= 1'b0;
		end else begin
			if (load_conv || load_pool) begin
				stage_cnt  <= load_conv ? 8'd1 : cnn_types_pkg::cnt_t'(LANES);
				stage_idx  <= '0;
				stage_last <= i_win_last;
			end else if (move) begin
				stage_cnt <= stage_cnt - 8'd1;
				stage_idx <= stage_idx + 8'd1;
			end
			if (move) begin
				o_out_valid <= 1'b1;
			end else if (i_out_ready) begin
				o_out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_conv) begin
			stage_q[0] <= i_conv_word;
		end else if (load_pool) begin
			stage_q <= i_pool_words;
		end
		if (move) begin
			o_out.word <= stage_q[stage_idx];
			o_out.lane <= stage_idx;	// lane 0 first
			o_out.last <= stage_last && (stage_cnt == 8'd1);
		end
	end

endmodule

// ==== verilog/cnn_engine_top.sv ====
`timescale 1ns/1ps

module cnn_engine_top #(
	parameter int LANES  = 4,
	parameter int ADDR_W = 10
) (
	input  logic                             clk,
	input  logic                             rst,
	input  cnn_cmd_pkg::cmd_t                i_cmd,
	input  logic                             i_cmd_valid,
	output logic                             o_cmd_ready,
	output logic                             o_rd_en,
	output logic [ADDR_W-1:0]                o_d_addr,
	output logic [ADDR_W-1:0]                o_w_addr,
	input  cnn_types_pkg::word_t [LANES-1:0] i_d_data,
	input  cnn_types_pkg::word_t [LANES-1:0] i_w_data,
	output cnn_types_pkg::out_beat_t         o_out,
	output logic                             o_out_valid,
	input  logic                             i_out_ready
);

	cnn_cmd_pkg::op_t                 op;
	logic                             stage_free;
	logic                             div_busy;
	logic                             last_taken;
	logic                             elem_valid;
	logic                             elem_first;
	logic                             elem_last;
	logic                             win_last;
	logic                             win_last_q;
	cnn_types_pkg::word_t             bias;
	cnn_types_pkg::cnt_t              kernel;
	cnn_types_pkg::acc_t  [LANES-1:0] mac_acc;
	logic                 [LANES-1:0] mac_valid;
	cnn_types_pkg::acc_t  [LANES-1:0] pool_res;
	logic                 [LANES-1:0] pool_valid;
	cnn_types_pkg::word_t             conv_word;
	logic                             conv_valid;
	cnn_types_pkg::word_t [LANES-1:0] max_words;
	cnn_types_pkg::word_t [LANES-1:0] quot;
	logic                             div_done;
	cnn_types_pkg::word_t [LANES-1:0] pool_words;
	logic                             pool_words_valid;
	logic                             is_conv;
	logic                             is_avg;

	assign is_conv = (op == cnn_cmd_pkg::op_conv);
	assign is_avg  = (op == cnn_cmd_pkg::op_avgpool);

	engine_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
		.clk(clk), .rst(rst), .i_cmd(i_cmd), .i_cmd_valid(i_cmd_valid),
		.o_cmd_ready(o_cmd_ready), .i_stage_free(stage_free), .i_div_busy(div_busy),
		.i_last_taken(last_taken), .o_op(op), .o_rd_en(o_rd_en),
		.o_d_addr(o_d_addr), .o_w_addr(o_w_addr), .o_elem_valid(elem_valid),
		.o_elem_first(elem_first), .o_elem_last(elem_last), .o_win_last(win_last),
		.o_bias(bias), .o_kernel(kernel)
	);

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		mac_lane u_mac (
			.clk(clk), .rst(rst), .i_valid(elem_valid && is_conv),
			.i_first(elem_first), .i_last(elem_last), .i_data(i_d_data[i]),
			.i_weight(i_w_data[i]), .o_acc(mac_acc[i]), .o_acc_valid(mac_valid[i])
		);
		pool_lane u_pool (
			.clk(clk), .rst(rst), .i_op(op), .i_valid(elem_valid && !is_conv),
			.i_first(elem_first), .i_last(elem_last), .i_data(i_d_data[i]),
			.o_result(pool_res[i]), .o_result_valid(pool_valid[i])
		);
		assign max_words[i] = pool_res[i][15:0];
	end

	lane_reduce #(.LANES(LANES)) u_reduce (
		.clk(clk), .rst(rst), .i_valid(&mac_valid), .i_accs(mac_acc),
		.i_bias(bias), .o_word(conv_word), .o_valid(conv_valid)
	);

	avg_divider #(.LANES(LANES)) u_div (
		.clk(clk), .rst(rst), .i_start(&pool_valid && is_avg), .i_sums(pool_res),
		.i_kernel(kernel), .o_busy(div_busy), .o_quot(quot), .o_done(div_done)
	);

	// max goes straight through, avg waits for the quotients
	assign pool_words       = is_avg ? quot : max_words;
	assign pool_words_valid = is_avg ? div_done : &pool_valid;

	// final-window flag held from the last element until the result loads
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			win_last_q <= 1'b0;
		end else if (elem_valid && elem_last) begin
			win_last_q <= win_last;
		end
	end

	result_serializer #(.LANES(LANES)) u_ser (
		.clk(clk), .rst(rst), .i_op(op), .i_conv_word(conv_word),
		.i_conv_valid(conv_valid), .i_pool_words(pool_words),
		.i_pool_valid(pool_words_valid), .i_win_last(win_last_q),
		.o_stage_free(stage_free), .o_out(o_out), .o_out_valid(o_out_valid),
		.i_out_ready(i_out_ready), .o_last_taken(last_taken)
	);

endmodule

// ==== verif/tb_cnn_engine.sv ====
`timescale 1ns/1ps

module tb_cnn_engine;

	localparam int LANES     = 4;
	localparam int ADDR_W    = 10;
	localparam int DEPTH     = 1 << ADDR_W;
	localparam int NUM_TESTS = 7;

	// one table row, the command plus how the testbench treats it
	typedef struct packed {
		cnn_cmd_pkg::cmd_t cmd;
		logic              neg_data;	// all data values negative
		logic              stall;		// random back-pressure
	} test_t;

	logic                             clk;
	logic                             rst;
	cnn_cmd_pkg::cmd_t                i_cmd;
	logic                             i_cmd_valid;
	logic                             o_cmd_ready;
	logic                             o_rd_en;
	logic [ADDR_W-1:0]                o_d_addr;
	logic [ADDR_W-1:0]                o_w_addr;
	cnn_types_pkg::word_t [LANES-1:0] i_d_data;
	cnn_types_pkg::word_t [LANES-1:0] i_w_data;
	cnn_types_pkg::out_beat_t         o_out;
	logic                             o_out_valid;
	logic                             i_out_ready;

	cnn_types_pkg::word_t     d_mem [DEPTH][LANES];
	cnn_types_pkg::word_t     w_mem [DEPTH][LANES];
	cnn_types_pkg::out_beat_t exp_beats [$];
	logic [ADDR_W-1:0]        exp_d_addr [$];
	logic [ADDR_W-1:0]        exp_w_addr [$];
	test_t                    tests [NUM_TESTS];
	integer                   seed;
	logic                     stall_mode;
	logic                     pend_valid;	// read waiting for its data
	logic [ADDR_W-1:0]        pend_d;
	logic [ADDR_W-1:0]        pend_w;
	logic                     held_valid;	// beat stalled on the last edge
	cnn_types_pkg::out_beat_t held_beat;

	cnn_engine_top #(.LANES(LANES), .ADDR_W(ADDR_W)) u_dut (
		.clk(clk), .rst(rst), .i_cmd(i_cmd), .i_cmd_valid(i_cmd_valid),
		.o_cmd_ready(o_cmd_ready), .o_rd_en(o_rd_en), .o_d_addr(o_d_addr),
		.o_w_addr(o_w_addr), .i_d_data(i_d_data), .i_w_data(i_w_data),
		.o_out(o_out), .o_out_valid(o_out_valid), .i_out_ready(i_out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task stop_with_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task check_beat(input cnn_types_pkg::out_beat_t got, input cnn_types_pkg::out_beat_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf(
				"mismatch o_out: got word %h lane %h last %h, expected word %h lane %h last %h",
				got.word, got.lane, got.last, exp.word, exp.lane, exp.last));
		end
	endtask

	task check_addr(input logic [ADDR_W-1:0] got_d, input logic [ADDR_W-1:0] got_w,
			input logic [ADDR_W-1:0] exp_d, input logic [ADDR_W-1:0] exp_w);
		if (got_d !== exp_d) begin
			stop_with_error($sformatf("mismatch o_d_addr: got %h expected %h", got_d, exp_d));
		end
		if (got_w !== exp_w) begin
			stop_with_error($sformatf("mismatch o_w_addr: got %h expected %h", got_w, exp_w));
		end
	endtask

	function automatic test_t make_test(input cnn_cmd_pkg::op_t op,
			input cnn_types_pkg::cnt_t k, input cnn_types_pkg::cnt_t n,
			input cnn_types_pkg::cnt_t s, input cnn_types_pkg::word_t bias,
			input logic neg_data, input logic stall);
		test_t t;
		t.cmd.op          = op;
		t.cmd.kernel_size = k;
		t.cmd.o_side      = n;
		t.cmd.stride      = s;
		t.cmd.bias        = bias;
		t.neg_data        = neg_data;
		t.stall           = stall;
		return t;
	endfunction

	// small values keep conv sums far from the 32-bit wrap
	task fill_memories(input logic neg_data);
		for (int a = 0; a < DEPTH; a++) begin
			for (int l = 0; l < LANES; l++) begin
				if (neg_data) begin
					d_mem[a][l] = cnn_types_pkg::word_t'(-(($random(seed) & 63) + 1));
				end else begin
					d_mem[a][l] = cnn_types_pkg::word_t'($random(seed) % 64);
				end
				w_mem[a][l] = cnn_types_pkg::word_t'($random(seed) % 16);
			end
		end
	endtask

	// expected beats and read addresses for one command
	task build_expected(input cnn_cmd_pkg::cmd_t cmd);
		int k;
		int n;
		int s;
		int acc;
		int v;
		cnn_types_pkg::out_beat_t beat;
		k = cmd.kernel_size;
		n = cmd.o_side;
		s = cmd.stride;
		exp_beats.delete();
		exp_d_addr.delete();
		exp_w_addr.delete();
		for (int j = 0; j < n; j++) begin
			for (int t = 0; t < k; t++) begin
				exp_d_addr.push_back(ADDR_W'(j * s + t));
				exp_w_addr.push_back(ADDR_W'(t));
			end
			if (cmd.op == cnn_cmd_pkg::op_conv) begin
				acc = int'($signed(cmd.bias));
				for (int l = 0; l < LANES; l++) begin
					for (int t = 0; t < k; t++) begin
						acc += int'($signed(d_mem[j*s+t][l])) * int'($signed(w_mem[t][l]));
					end
				end
				beat.word = (acc < 0) ? '0 : acc[15:0];	// relu
				beat.lane = '0;
				beat.last = (j == n - 1);
				exp_beats.push_back(beat);
			end else begin
				for (int l = 0; l < LANES; l++) begin
					acc = int'($signed(d_mem[j*s][l]));
					for (int t = 1; t < k; t++) begin
						v = int'($signed(d_mem[j*s+t][l]));
						if (cmd.op == cnn_cmd_pkg::op_maxpool) begin
							acc = (v > acc) ? v : acc;
						end else begin
							acc = acc + v;
						end
					end
					if (cmd.op == cnn_cmd_pkg::op_avgpool) begin
						acc = acc / k;	// int division truncates toward zero
					end
					beat.word = acc[15:0];
					beat.lane = cnn_types_pkg::cnt_t'(l);
					beat.last = (j == n - 1) && (l == LANES - 1);
					exp_beats.push_back(beat);
				end
			end
		end
	endtask

	// one falling edge: drive ready, check outputs, answer reads
	task step_cycle;
		logic [ADDR_W-1:0] ed;
		logic [ADDR_W-1:0] ew;
		@(negedge clk);
		if (held_valid) begin
			if (!o_out_valid) begin
				stop_with_error("o_out_valid dropped while the output was stalled");
			end
			check_beat(o_out, held_beat);
		end
		i_out_ready = stall_mode ? (($random(seed) & 1) != 0) : 1'b1;
		held_valid  = o_out_valid && !i_out_ready;	// must still be there next edge
		held_beat   = o_out;
		if (o_out_valid && i_out_ready) begin
			if (exp_beats.size() == 0) begin
				stop_with_error("output beat accepted when none was expected");
			end else begin
				check_beat(o_out, exp_beats.pop_front());
			end
		end
		if (pend_valid) begin
			for (int l = 0; l < LANES; l++) begin
				i_d_data[l] = d_mem[pend_d][l];
				i_w_data[l] = w_mem[pend_w][l];
			end
		end
		pend_valid = o_rd_en;
		pend_d     = o_d_addr;
		pend_w     = o_w_addr;
		if (o_rd_en) begin
			if (exp_d_addr.size() == 0) begin
				stop_with_error("memory read issued when none was expected");
			end else begin
				ed = exp_d_addr.pop_front();
				ew = exp_w_addr.pop_front();
				check_addr(o_d_addr, o_w_addr, ed, ew);
			end
		end
	endtask

	task wait_cmd_ready(input int limit, input string what);
		int cnt;
		cnt = 0;
		while (!o_cmd_ready) begin
			step_cycle();
			cnt++;
			if (cnt > limit) begin
				stop_with_error(what);
			end
		end
	endtask

	task run_command(input test_t t);
		int cnt;
		stall_mode = t.stall;
		fill_memories(t.neg_data);
		build_expected(t.cmd);
		wait_cmd_ready(20, "timeout waiting for o_cmd_ready before a command");
		i_cmd       = t.cmd;
		i_cmd_valid = 1'b1;
		step_cycle();
		i_cmd_valid = 1'b0;
		cnt = 0;
		while (exp_beats.size() > 0) begin
			step_cycle();
			if (o_cmd_ready) begin
				stop_with_error("o_cmd_ready rose before the last beat was taken");
			end
			cnt++;
			if (cnt > 4000) begin
				stop_with_error("timeout waiting for output beats");
			end
		end
		if (exp_d_addr.size() != 0) begin
			stop_with_error("command finished without issuing all memory reads");
		end
		wait_cmd_ready(4, "o_cmd_ready did not return after the last beat was taken");
	endtask

	initial begin
		seed        = 5;
		rst         = 1'b1;
		i_cmd       = '0;
		i_cmd_valid = 1'b0;
		i_d_data    = '0;
		i_w_data    = '0;
		i_out_ready = 1'b0;
		stall_mode  = 1'b0;
		pend_valid  = 1'b0;
		held_valid  = 1'b0;

		tests[0] = make_test(cnn_cmd_pkg::op_conv, 8'd3, 8'd4, 8'd1, 16'd100, 1'b0, 1'b0);
		tests[1] = make_test(cnn_cmd_pkg::op_conv, 8'd3, 8'd3, 8'd1, 16'h8000, 1'b0, 1'b0);
		tests[2] = make_test(cnn_cmd_pkg::op_maxpool, 8'd4, 8'd3, 8'd2, 16'd0, 1'b0, 1'b0);
		tests[3] = make_test(cnn_cmd_pkg::op_avgpool, 8'd3, 8'd3, 8'd1, 16'd0, 1'b1, 1'b0);
		tests[4] = make_test(cnn_cmd_pkg::op_avgpool, 8'd5, 8'd2, 8'd2, 16'd0, 1'b1, 1'b0);
		tests[5] = make_test(cnn_cmd_pkg::op_maxpool, 8'd4, 8'd3, 8'd2, 16'd0, 1'b0, 1'b1);
		tests[6] = make_test(cnn_cmd_pkg::op_conv, 8'd2, 8'd2, 8'd3, 16'd5, 1'b0, 1'b0);	// back to back

		repeat (5) @(negedge clk);
		rst = 1'b0;
		if (!o_cmd_ready || o_rd_en || o_out_valid) begin
			stop_with_error("wrong port levels after reset");
		end

		for (int i = 0; i < NUM_TESTS; i++) begin
			run_command(tests[i]);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== cnn_engine_top.f ====
verilog/cnn_types_pkg.sv
verilog/cnn_cmd_pkg.sv
verilog/engine_ctrl.sv
verilog/mac_lane.sv
verilog/pool_lane.sv
verilog/lane_reduce.sv
verilog/avg_divider.sv
verilog/result_serializer.sv
verilog/cnn_engine_top.sv
verif/tb_cnn_engine.sv
